//--- ext_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// External bus package
// Bus widths, power-switch address map, latencies and slow-memory states
////////////////////////////////////////////////////////////////////////////

package ext_bus_pkg;

  // Bus fields
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Slow memory
  localparam int unsigned MEM_NUM_WORDS = 1024;
  typedef logic [$clog2(MEM_NUM_WORDS)-1:0] mem_idx_t;

  localparam int unsigned SLOW_MEM_LATENCY = 3;
  typedef logic [$clog2(SLOW_MEM_LATENCY+1)-1:0] mem_lat_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_BUSY,
    MEM_RESP
  } mem_state_e;

  // Power-switch region, matched on address bits 31:12
  localparam addr_t PWR_SW_BASE = 32'h2000_0000;
  typedef logic [11:0] reg_offs_t;
  localparam reg_offs_t PWR_SW_SWITCH_OFFS = 12'h000;
  localparam reg_offs_t PWR_SW_ACK_OFFS    = 12'h004;

  localparam int unsigned NUM_DOMAINS = 4;
  typedef logic [NUM_DOMAINS-1:0] domain_mask_t;

  // Switch cell delay in cycles
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // Request FIFO in front of the slow memory
  localparam int unsigned FIFO_DEPTH = 2;
  typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // Router in-flight limit
  localparam int unsigned MAX_OUTSTANDING = 4;
  typedef logic [2:0] outst_cnt_t;

endpackage

//--- obi_if.sv
////////////////////////////////////////////////////////////////////////////
// OBI bus interface
// Request channel from master, grant and response channel from slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface obi_if;
  import ext_bus_pkg::*;

  // Request
  logic  req;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;

  // Response
  logic  gnt;
  logic  rvalid;
  data_t rdata;

  modport master (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- ext_bus_router.sv
////////////////////////////////////////////////////////////////////////////
// External bus router
// Steers bridge requests to slow memory or power switch, keeps order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ext_bus_router (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Bridge request
  input  logic               req_i,
  input  logic               we_i,
  input  ext_bus_pkg::be_t   be_i,
  input  ext_bus_pkg::addr_t addr_i,
  input  ext_bus_pkg::data_t wdata_i,
  // Bridge response
  output logic               gnt_o,
  output logic               rvalid_o,
  output ext_bus_pkg::data_t rdata_o,
  // Slaves
  obi_if.master              mem_o,
  obi_if.master              pwr_o
);
  import ext_bus_pkg::*;

  logic       sel_pwr;
  logic       slave_gnt;
  logic       stall;
  outst_cnt_t outst_cnt_q;
  logic       outst_pwr_q;

  // Anything outside the power-switch window goes to memory
  assign sel_pwr = (addr_i[31:12] == PWR_SW_BASE[31:12]);

  // Hold off a target change until the other slave has drained
  assign stall = (outst_cnt_q == outst_cnt_t'(MAX_OUTSTANDING)) ||
                 ((outst_cnt_q != '0) && (outst_pwr_q != sel_pwr));

  assign mem_o.req   = req_i & ~sel_pwr & ~stall;
  assign mem_o.we    = we_i;
  assign mem_o.be    = be_i;
  assign mem_o.addr  = addr_i;
  assign mem_o.wdata = wdata_i;

  assign pwr_o.req   = req_i & sel_pwr & ~stall;
  assign pwr_o.we    = we_i;
  assign pwr_o.be    = be_i;
  assign pwr_o.addr  = addr_i;
  assign pwr_o.wdata = wdata_i;

  assign slave_gnt = sel_pwr ? pwr_o.gnt : mem_o.gnt;
  assign gnt_o     = req_i & ~stall & slave_gnt;

  // Only one slave can have responses pending, so a plain merge is enough
  assign rvalid_o = mem_o.rvalid | pwr_o.rvalid;
  assign rdata_o  = pwr_o.rvalid ? pwr_o.rdata : mem_o.rdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outst_cnt_q <= '0;
    end else begin
      unique case ({gnt_o, rvalid_o})
        2'b10:   outst_cnt_q <= outst_cnt_q + outst_cnt_t'(1);
        2'b01:   outst_cnt_q <= outst_cnt_q - outst_cnt_t'(1);
        default: outst_cnt_q <= outst_cnt_q;
      endcase
    end
  end

  // Target of the responses in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outst_pwr_q <= 1'b0;
    end else if (gnt_o) begin
      outst_pwr_q <= sel_pwr;
    end
  end

endmodule

//--- obi_fifo.sv
////////////////////////////////////////////////////////////////////////////
// OBI request FIFO
// Queues requests ahead of the slow memory, responses pass straight back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_fifo (
  input  logic  clk_i,
  input  logic  arst_n_i,
  obi_if.slave  producer_i,
  obi_if.master consumer_o
);
  import ext_bus_pkg::*;

  logic      we_q    [FIFO_DEPTH];
  be_t       be_q    [FIFO_DEPTH];
  addr_t     addr_q  [FIFO_DEPTH];
  data_t     wdata_q [FIFO_DEPTH];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      push;
  logic      pop;

  assign producer_i.gnt = (count_q != fifo_cnt_t'(FIFO_DEPTH));
  assign push           = producer_i.req & producer_i.gnt;

  // Head entry is presented downstream
  assign consumer_o.req   = (count_q != '0);
  assign consumer_o.we    = we_q[rd_ptr_q];
  assign consumer_o.be    = be_q[rd_ptr_q];
  assign consumer_o.addr  = addr_q[rd_ptr_q];
  assign consumer_o.wdata = wdata_q[rd_ptr_q];
  assign pop              = consumer_o.req & consumer_o.gnt;

  assign producer_i.rvalid = consumer_o.rvalid;
  assign producer_i.rdata  = consumer_o.rdata;

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_q[wr_ptr_q]    <= producer_i.we;
      be_q[wr_ptr_q]    <= producer_i.be;
      addr_q[wr_ptr_q]  <= producer_i.addr;
      wdata_q[wr_ptr_q] <= producer_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_t'(FIFO_DEPTH-1)) ? '0 : wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_t'(FIFO_DEPTH-1)) ? '0 : rd_ptr_q + fifo_ptr_t'(1);
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + fifo_cnt_t'(1);
        2'b01:   count_q <= count_q - fifo_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- slow_memory.sv
////////////////////////////////////////////////////////////////////////////
// Slow memory
// Word memory with byte enables, busy for a fixed time on every access
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module slow_memory (
  input  logic clk_i,
  input  logic arst_n_i,
  obi_if.slave bus_i
);
  import ext_bus_pkg::*;

  data_t      mem [MEM_NUM_WORDS];
  data_t      rdata_q;
  mem_idx_t   idx;
  logic       access;
  mem_state_e state_q;
  mem_lat_t   lat_cnt_q;

  assign idx    = mem_idx_t'(bus_i.addr[11:2]);
  assign access = bus_i.req & bus_i.gnt;

  // One access at a time
  assign bus_i.gnt    = (state_q == MEM_IDLE);
  assign bus_i.rvalid = (state_q == MEM_RESP);
  assign bus_i.rdata  = rdata_q;

  // Write lands at grant, read data is captured at grant
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bus_i.we) begin
        for (int b = 0; b < $bits(be_t); b++) begin
          if (bus_i.be[b]) begin
            mem[idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= MEM_IDLE;
      lat_cnt_q <= '0;
    end else begin
      unique case (state_q)
        MEM_IDLE: begin
          if (access) begin
            state_q   <= MEM_BUSY;
            lat_cnt_q <= mem_lat_t'(SLOW_MEM_LATENCY - 1);
          end
        end
        MEM_BUSY: begin
          if (lat_cnt_q == '0) begin
            state_q <= MEM_RESP;
          end else begin
            lat_cnt_q <= lat_cnt_q - mem_lat_t'(1);
          end
        end
        MEM_RESP: begin
          state_q <= MEM_IDLE;
        end
        default: begin
          state_q <= MEM_IDLE;
        end
      endcase
    end
  end

endmodule

//--- power_switch_model.sv
////////////////////////////////////////////////////////////////////////////
// Power switch cell model
// Register-mapped switch_n per domain, ack_n follows after a fixed delay
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module power_switch_model (
  input  logic clk_i,
  input  logic arst_n_i,
  obi_if.slave bus_i
);
  import ext_bus_pkg::*;

  domain_mask_t switch_n_q;
  domain_mask_t ack_chain_q [SWITCH_ACK_LATENCY];
  domain_mask_t ack_n;
  reg_offs_t    offs;
  logic         access;
  logic         switch_wr;
  data_t        rd_data;
  logic         rvalid_q;
  data_t        rdata_q;

  assign bus_i.gnt    = 1'b1;
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

  assign offs      = bus_i.addr[11:0];
  assign access    = bus_i.req & bus_i.gnt;
  assign switch_wr = access & bus_i.we & bus_i.be[0] & (offs == PWR_SW_SWITCH_OFFS);

  // Oldest stage is what the cells report
  assign ack_n = ack_chain_q[SWITCH_ACK_LATENCY-1];

  always_comb begin
    unique case (offs)
      PWR_SW_SWITCH_OFFS: rd_data = data_t'(switch_n_q);
      PWR_SW_ACK_OFFS:    rd_data = data_t'(ack_n);
      default:            rd_data = '0;
    endcase
  end

  // Domains come up switched off
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_n_q <= '1;
    end else if (switch_wr) begin
      switch_n_q <= bus_i.wdata[NUM_DOMAINS-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_chain_q[i] <= '1;
      end
    end else begin
      ack_chain_q[0] <= switch_n_q;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_chain_q[i] <= ack_chain_q[i-1];
      end
    end
  end

  // Response one cycle after grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_data;
    end
  end

endmodule

//--- ext_harness.sv
////////////////////////////////////////////////////////////////////////////
// External bus harness
// Bridge port into router, request FIFO, slow memory and switch model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ext_harness (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Bridge request
  input  logic               req_i,
  input  logic               we_i,
  input  ext_bus_pkg::be_t   be_i,
  input  ext_bus_pkg::addr_t addr_i,
  input  ext_bus_pkg::data_t wdata_i,
  // Bridge response
  output logic               gnt_o,
  output logic               rvalid_o,
  output ext_bus_pkg::data_t rdata_o
);

  obi_if mem_bus ();
  obi_if fifo_bus ();
  obi_if pwr_bus ();

  ext_bus_router i_router (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .mem_o    (mem_bus),
    .pwr_o    (pwr_bus)
  );

  // Extra latency in front of the slow memory
  obi_fifo i_obi_fifo (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .producer_i (mem_bus),
    .consumer_o (fifo_bus)
  );

  slow_memory i_slow_memory (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (fifo_bus)
  );

  power_switch_model i_power_switch (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (pwr_bus)
  );

endmodule

//--- tb_ext_harness.sv
////////////////////////////////////////////////////////////////////////////
// External bus harness testbench
// Drives the bridge port and checks reads against a shadow model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ext_harness;
  import ext_bus_pkg::*;

  localparam int N_RAND      = 16;
  localparam int N_PIPE      = 8;
  localparam int POLL_LIMIT  = int'(SWITCH_ACK_LATENCY) + 10;
  localparam int N_ACCESSES  = 2 + 4 * N_RAND + 2 + POLL_LIMIT + 4 * N_PIPE;
  // Worst serial memory access including FIFO, busy time and drain
  localparam int ACCESS_CYC  = 12;
  localparam int CYCLE_LIMIT = 5 + 50 + N_ACCESSES * ACCESS_CYC;

  localparam int KIND_DATA  = 0;
  localparam int KIND_ACK   = 1;
  localparam int KIND_WRITE = 2;

  logic  clk;
  logic  arst_n;
  logic  req;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;
  logic  gnt;
  logic  rvalid;
  data_t rdata;

  integer       seed;
  int           err_cnt;
  int           check_cnt;
  int           grant_cnt;
  int           resp_cnt;
  int           cycle_cnt;
  int           sw_wr_cyc;
  data_t        last_rdata;
  data_t        shadow_mem [MEM_NUM_WORDS];
  domain_mask_t shadow_sw;
  domain_mask_t sw_prev;
  addr_t        mem_addrs [N_RAND];

  // Expectations in request order
  int           kind_q [$];
  data_t        exp_q [$];

  ext_harness i_dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .req_i    (req),
    .we_i     (we),
    .be_i     (be),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic in_pwr_region(input addr_t a);
    return a[31:12] == PWR_SW_BASE[31:12];
  endfunction

  function automatic addr_t pwr_addr(input reg_offs_t offs);
    return PWR_SW_BASE | addr_t'(offs);
  endfunction

  // Random word address that falls through to the slow memory
  function automatic addr_t rand_mem_addr();
    addr_t a;
    a = addr_t'($random(seed));
    a[1:0] = 2'b00;
    if (in_pwr_region(a)) begin
      a[31] = ~a[31];
    end
    return a;
  endfunction

  // Reference read value with ack_n lagging switch_n by the cell delay
  function automatic data_t expected_read(input addr_t a);
    if (in_pwr_region(a)) begin
      if (a[11:0] == PWR_SW_SWITCH_OFFS) begin
        return data_t'(shadow_sw);
      end
      if (a[11:0] == PWR_SW_ACK_OFFS) begin
        if (cycle_cnt - sw_wr_cyc > int'(SWITCH_ACK_LATENCY)) begin
          return data_t'(shadow_sw);
        end
        return data_t'(sw_prev);
      end
      return '0;
    end
    return shadow_mem[a[11:2]];
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input domain_mask_t got, input domain_mask_t exp,
                              input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Drive one request and hold it until granted
  task automatic issue(input logic wr, input addr_t a, input data_t d, input be_t bemask);
    mem_idx_t idx;
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    be    = bemask;
    @(negedge clk);
    while (gnt !== 1'b1) begin
      @(negedge clk);
    end
    idx = a[11:2];
    if (wr) begin
      if (in_pwr_region(a)) begin
        if (a[11:0] == PWR_SW_SWITCH_OFFS && bemask[0]) begin
          sw_prev   = shadow_sw;
          shadow_sw = d[NUM_DOMAINS-1:0];
          sw_wr_cyc = cycle_cnt;
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (bemask[b]) begin
            shadow_mem[idx][b*8 +: 8] = d[b*8 +: 8];
          end
        end
      end
      kind_q.push_back(KIND_WRITE);
    end else if (in_pwr_region(a) && a[11:0] == PWR_SW_ACK_OFFS) begin
      kind_q.push_back(KIND_ACK);
    end else begin
      kind_q.push_back(KIND_DATA);
    end
    exp_q.push_back(expected_read(a));
    grant_cnt++;
    @(posedge clk);
    #1;
  endtask

  task automatic idle();
    req = 1'b0;
    we  = 1'b0;
  endtask

  // Wait for every granted request to respond
  task automatic drain();
    idle();
    while (resp_cnt != grant_cnt) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic report(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, err_cnt - errs_before);
  endtask

  always @(negedge clk) begin : response_monitor
    int    kind;
    data_t exp;
    if (arst_n && rvalid) begin
      if (kind_q.size() == 0) begin
        err_cnt++;
        $display("response at %0t with no request outstanding", $time);
      end else begin
        kind = kind_q.pop_front();
        exp  = exp_q.pop_front();
        if (kind == KIND_DATA) begin
          check_data(rdata, exp, "read data");
        end else if (kind == KIND_ACK) begin
          check_status(rdata[NUM_DOMAINS-1:0], exp[NUM_DOMAINS-1:0], "ack_n");
          check_data(rdata >> NUM_DOMAINS, '0, "ack_n upper bits");
        end
      end
      last_rdata = rdata;
      resp_cnt++;
    end
  end

  initial begin
    int           errs;
    domain_mask_t new_sw;
    logic         reached;
    seed      = 10;
    err_cnt   = 0;
    check_cnt = 0;
    grant_cnt = 0;
    resp_cnt  = 0;
    cycle_cnt = 0;
    sw_wr_cyc = 0;
    shadow_sw = '1;
    sw_prev   = '1;
    arst_n    = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    be        = '0;
    addr      = '0;
    wdata     = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Reset state
    errs = err_cnt;
    @(negedge clk);
    if (rvalid !== 1'b0 || gnt !== 1'b0) begin
      err_cnt++;
      $display("rvalid_o or gnt_o is not low after reset");
    end
    @(posedge clk);
    #1;
    issue(1'b0, pwr_addr(PWR_SW_SWITCH_OFFS), '0, '0);
    issue(1'b0, pwr_addr(PWR_SW_ACK_OFFS), '0, '0);
    drain();
    report("reset", errs);

    // Full-word writes and readback
    errs = err_cnt;
    for (int i = 0; i < N_RAND; i++) begin
      mem_addrs[i] = rand_mem_addr();
      issue(1'b1, mem_addrs[i], data_t'($random(seed)), '1);
    end
    for (int i = 0; i < N_RAND; i++) begin
      issue(1'b0, mem_addrs[i], '0, '0);
    end
    drain();
    report("full_word", errs);

    // Partial writes with random byte enables
    errs = err_cnt;
    for (int i = 0; i < N_RAND; i++) begin
      issue(1'b1, mem_addrs[i], data_t'($random(seed)), be_t'($random(seed)));
    end
    for (int i = 0; i < N_RAND; i++) begin
      issue(1'b0, mem_addrs[i], '0, '0);
    end
    drain();
    report("byte_enable", errs);

    // Switch write, then poll ack_n until it follows
    errs   = err_cnt;
    new_sw = domain_mask_t'($random(seed));
    if (new_sw == shadow_sw) begin
      new_sw = ~new_sw;
    end
    issue(1'b1, pwr_addr(PWR_SW_SWITCH_OFFS), data_t'(new_sw), '1);
    issue(1'b0, pwr_addr(PWR_SW_SWITCH_OFFS), '0, '0);
    drain();
    reached = 1'b0;
    for (int k = 0; k < POLL_LIMIT && !reached; k++) begin
      issue(1'b0, pwr_addr(PWR_SW_ACK_OFFS), '0, '0);
      drain();
      if (last_rdata[NUM_DOMAINS-1:0] == new_sw) begin
        reached = 1'b1;
      end
    end
    if (!reached) begin
      err_cnt++;
      $display("ack_n did not reach the written switch_n within %0d polls", POLL_LIMIT);
    end
    report("switch_ack", errs);

    // Pipelined traffic alternating between the two slaves
    errs = err_cnt;
    for (int i = 0; i < N_PIPE; i++) begin
      issue(1'b1, mem_addrs[i], data_t'($random(seed)), '1);
      issue(1'b0, pwr_addr(PWR_SW_SWITCH_OFFS), '0, '0);
      issue(1'b0, mem_addrs[i], '0, '0);
      issue(1'b0, pwr_addr((i % 2 == 0) ? PWR_SW_ACK_OFFS : reg_offs_t'(12'h008)), '0, '0);
    end
    drain();
    if (kind_q.size() != 0) begin
      err_cnt++;
      $display("%0d requests never got a response", kind_q.size());
    end
    report("pipelined", errs);

    $display("checks %0d, errors %0d, responses %0d", check_cnt, err_cnt, resp_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- ext_harness.f
ext_bus_pkg.sv
obi_if.sv
ext_bus_router.sv
obi_fifo.sv
slow_memory.sv
power_switch_model.sv
ext_harness.sv
tb_ext_harness.sv

//--- run_sim.sh
#!/bin/sh
# Build the external bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ext_harness -f ext_harness.f -o sim_ext \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_ext)
echo "$out"

echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
